//--- verilog/rv_dec_pkg.sv
`default_nettype none

package rv_dec_pkg;

  parameter int XLEN = 32;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    OP_IMM   = 7'b0010011,
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    OP       = 7'b0110011,
    JAL      = 7'b1101111,
    JALR     = 7'b1100111,
    BRANCH   = 7'b1100011,
    LOAD     = 7'b0000011,
    STORE    = 7'b0100011,
    MISC_MEM = 7'b0001111,
    SYSTEM   = 7'b1110011
  } opcode_t;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_PRIV    = 3'b000;
  localparam logic [2:0] F3_CSR_RSV = 3'b100;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // funct12 of the privileged instructions
  localparam logic [11:0] F12_ECALL  = 12'h000;
  localparam logic [11:0] F12_EBREAK = 12'h001;
  localparam logic [11:0] F12_MRET   = 12'h302;
  localparam logic [11:0] F12_WFI    = 12'h105;

  typedef enum logic [1:0] {
    ZERO   = 2'd0,
    REG_RF = 2'd1,
    IMM    = 2'd2,
    PC     = 2'd3
  } operand_src_t;

  typedef enum logic [1:0] {
    LSU_NONE  = 2'd0,
    LSU_LOAD  = 2'd1,
    LSU_STORE = 2'd2
  } lsu_op_t;

  // Encoded as funct3 of loads and stores
  typedef enum logic [2:0] {
    LSU_B  = 3'b000,
    LSU_H  = 3'b001,
    LSU_W  = 3'b010,
    LSU_BU = 3'b100,
    LSU_HU = 3'b101
  } lsu_width_t;

  typedef enum logic [2:0] {
    CSR_NONE = 3'b000,
    RW       = 3'b001,
    RS       = 3'b010,
    RC       = 3'b011,
    RWI      = 3'b101,
    RSI      = 3'b110,
    RCI      = 3'b111
  } csr_op_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  typedef struct packed {
    logic            active;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] pc_addr;
  } trap_info_t;

  typedef struct packed {
    csr_op_t     op;
    logic [11:0] addr;
    logic        rs1_is_x0;
  } csr_info_t;

  typedef struct packed {
    logic [XLEN-1:0] pc_dec;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [4:0]      rd_addr;
    operand_src_t    rs1_op;
    operand_src_t    rs2_op;
    logic [XLEN-1:0] imm;
    logic [2:0]      f3;
    logic            f7_alt;
    logic            rshift_arith;
    logic            we_rd;
    logic            jump;
    logic            branch;
    lsu_op_t         lsu;
    lsu_width_t      lsu_w;
    csr_info_t       csr;
    logic            ecall;
    logic            ebreak;
    logic            mret;
    logic            wfi;
    trap_info_t      trap;
  } id_ex_t;

endpackage

`default_nettype wire

//--- verilog/rf_read_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rf_read_if;

  logic [4:0]                  rs1_addr;
  logic [4:0]                  rs2_addr;
  logic                        re;
  logic [rv_dec_pkg::XLEN-1:0] rs1_data;
  logic [rv_dec_pkg::XLEN-1:0] rs2_data;

  modport stage (
    output rs1_addr,
    output rs2_addr,
    output re,
    input  rs1_data,
    input  rs2_data
  );

  modport rf (
    input  rs1_addr,
    input  rs2_addr,
    input  re,
    output rs1_data,
    output rs2_data
  );

endinterface

`default_nettype wire

//--- verilog/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
  input  wire rv_dec_pkg::instr_u instr_i,
  output rv_dec_pkg::id_ex_t      ctrl_o
);

  logic [rv_dec_pkg::XLEN-1:0] imm_i_type;
  logic [rv_dec_pkg::XLEN-1:0] imm_s_type;
  logic [rv_dec_pkg::XLEN-1:0] imm_b_type;
  logic [rv_dec_pkg::XLEN-1:0] imm_u_type;
  logic [rv_dec_pkg::XLEN-1:0] imm_j_type;
  logic [rv_dec_pkg::XLEN-1:0] imm_zimm;
  logic [2:0]                  f3;
  logic [6:0]                  f7;
  logic                        illegal;

  assign f3 = instr_i.r_fmt.funct3;
  assign f7 = instr_i.r_fmt.funct7;

  assign imm_i_type = {{20{instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
  assign imm_s_type = {{20{instr_i.s_fmt.imm_11_5[6]}}, instr_i.s_fmt.imm_11_5,
                       instr_i.s_fmt.imm_4_0};
  assign imm_b_type = {{20{instr_i.b_fmt.imm_12}}, instr_i.b_fmt.imm_11,
                       instr_i.b_fmt.imm_10_5, instr_i.b_fmt.imm_4_1, 1'b0};
  assign imm_u_type = {instr_i.u_fmt.imm_31_12, 12'h000};
  assign imm_j_type = {{12{instr_i.j_fmt.imm_20}}, instr_i.j_fmt.imm_19_12,
                       instr_i.j_fmt.imm_11, instr_i.j_fmt.imm_10_1, 1'b0};
  // Unsigned 5-bit immediate of the CSR*I forms
  assign imm_zimm   = {27'd0, instr_i.i_fmt.rs1};

  always_comb begin
    ctrl_o          = '0;
    illegal         = 1'b0;
    ctrl_o.rs1_addr = instr_i.r_fmt.rs1;
    ctrl_o.rs2_addr = instr_i.r_fmt.rs2;
    ctrl_o.rd_addr  = instr_i.r_fmt.rd;

    case (instr_i.r_fmt.opcode)
      rv_dec_pkg::OP_IMM: begin
        ctrl_o.f3     = f3;
        ctrl_o.rs1_op = rv_dec_pkg::REG_RF;
        ctrl_o.rs2_op = rv_dec_pkg::IMM;
        ctrl_o.imm    = imm_i_type;
        ctrl_o.we_rd  = 1'b1;
        // Shift amounts share the upper immediate bits with funct7
        if (f3 == rv_dec_pkg::F3_SLL) begin
          illegal = (f7 != rv_dec_pkg::F7_BASE);
        end else if (f3 == rv_dec_pkg::F3_SRL_SRA) begin
          illegal             = (f7 != rv_dec_pkg::F7_BASE) && (f7 != rv_dec_pkg::F7_ALT);
          ctrl_o.rshift_arith = f7[5];
        end
      end
      rv_dec_pkg::LUI: begin
        ctrl_o.rs1_op = rv_dec_pkg::ZERO;
        ctrl_o.rs2_op = rv_dec_pkg::IMM;
        ctrl_o.imm    = imm_u_type;
        ctrl_o.we_rd  = 1'b1;
      end
      rv_dec_pkg::AUIPC: begin
        ctrl_o.rs1_op = rv_dec_pkg::PC;
        ctrl_o.rs2_op = rv_dec_pkg::IMM;
        ctrl_o.imm    = imm_u_type;
        ctrl_o.we_rd  = 1'b1;
      end
      rv_dec_pkg::OP: begin
        ctrl_o.f3     = f3;
        ctrl_o.rs1_op = rv_dec_pkg::REG_RF;
        ctrl_o.rs2_op = rv_dec_pkg::REG_RF;
        ctrl_o.f7_alt = f7[5];
        ctrl_o.we_rd  = 1'b1;
        if (f3 == rv_dec_pkg::F3_SRL_SRA) begin
          ctrl_o.rshift_arith = f7[5];
        end
        // Only ADD/SUB and SRL/SRA have an alternate funct7
        illegal = (f7 != rv_dec_pkg::F7_BASE) &&
                  !((f7 == rv_dec_pkg::F7_ALT) &&
                    ((f3 == rv_dec_pkg::F3_ADD_SUB) || (f3 == rv_dec_pkg::F3_SRL_SRA)));
      end
      rv_dec_pkg::JAL: begin
        ctrl_o.jump   = 1'b1;
        ctrl_o.rs1_op = rv_dec_pkg::PC;
        ctrl_o.rs2_op = rv_dec_pkg::IMM;
        ctrl_o.imm    = imm_j_type;
        ctrl_o.we_rd  = 1'b1;
      end
      rv_dec_pkg::JALR: begin
        ctrl_o.jump   = 1'b1;
        ctrl_o.rs1_op = rv_dec_pkg::REG_RF;
        ctrl_o.rs2_op = rv_dec_pkg::IMM;
        ctrl_o.imm    = imm_i_type;
        ctrl_o.we_rd  = 1'b1;
        illegal       = (f3 != 3'b000);
      end
      rv_dec_pkg::BRANCH: begin
        ctrl_o.branch = 1'b1;
        ctrl_o.f3     = f3;
        ctrl_o.rs1_op = rv_dec_pkg::REG_RF;
        ctrl_o.rs2_op = rv_dec_pkg::REG_RF;
        ctrl_o.imm    = imm_b_type;
        illegal       = (f3[2:1] == 2'b01);
      end
      rv_dec_pkg::LOAD: begin
        ctrl_o.lsu    = rv_dec_pkg::LSU_LOAD;
        ctrl_o.lsu_w  = rv_dec_pkg::lsu_width_t'(f3);
        ctrl_o.rs1_op = rv_dec_pkg::REG_RF;
        ctrl_o.rs2_op = rv_dec_pkg::IMM;
        ctrl_o.imm    = imm_i_type;
        ctrl_o.we_rd  = 1'b1;
        illegal       = !(f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
      end
      rv_dec_pkg::STORE: begin
        ctrl_o.lsu    = rv_dec_pkg::LSU_STORE;
        ctrl_o.lsu_w  = rv_dec_pkg::lsu_width_t'(f3);
        ctrl_o.rs1_op = rv_dec_pkg::REG_RF;
        ctrl_o.rs2_op = rv_dec_pkg::IMM;
        ctrl_o.imm    = imm_s_type;
        illegal       = (f3 > 3'b010);
      end
      rv_dec_pkg::MISC_MEM: begin
        // FENCE runs as a NOP in an in-order pipe
      end
      rv_dec_pkg::SYSTEM: begin
        if (f3 == rv_dec_pkg::F3_PRIV) begin
          if ((instr_i.i_fmt.rd != 5'd0) || (instr_i.i_fmt.rs1 != 5'd0)) begin
            illegal = 1'b1;
          end else begin
            case (instr_i.i_fmt.imm)
              rv_dec_pkg::F12_ECALL:  ctrl_o.ecall  = 1'b1;
              rv_dec_pkg::F12_EBREAK: ctrl_o.ebreak = 1'b1;
              rv_dec_pkg::F12_MRET:   ctrl_o.mret   = 1'b1;
              rv_dec_pkg::F12_WFI:    ctrl_o.wfi    = 1'b1;
              default:                illegal       = 1'b1;
            endcase
          end
        end else if (f3 != rv_dec_pkg::F3_CSR_RSV) begin
          if (f3[2]) begin
            ctrl_o.rs1_op = rv_dec_pkg::IMM;
          end else begin
            ctrl_o.rs1_op = rv_dec_pkg::REG_RF;
          end
          ctrl_o.imm            = imm_zimm;
          ctrl_o.csr.op         = rv_dec_pkg::csr_op_t'(f3);
          ctrl_o.csr.addr       = instr_i.i_fmt.imm;
          ctrl_o.csr.rs1_is_x0  = (instr_i.i_fmt.rs1 == 5'd0);
          ctrl_o.we_rd          = (instr_i.i_fmt.rd != 5'd0);
        end else begin
          illegal = 1'b1;
        end
      end
      default: begin
        illegal = 1'b1;
      end
    endcase

    if (illegal) begin
      ctrl_o             = '0;
      ctrl_o.trap.active = 1'b1;
      ctrl_o.trap.mtval  = instr_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire logic                        clk,
  input  wire logic                        rst_n_i,
  rf_read_if.rf                            rd_i,
  input  wire logic                        we_i,
  input  wire logic [4:0]                  rd_addr_i,
  input  wire logic [rv_dec_pkg::XLEN-1:0] rd_data_i
);

  // x0 has no storage
  logic [rv_dec_pkg::XLEN-1:0] regs [1:31];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_addr_i != 5'd0)) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  // No write bypass, a same-cycle read returns the old value
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_i.rs1_data <= '0;
      rd_i.rs2_data <= '0;
    end else if (rd_i.re) begin
      if (rd_i.rs1_addr == 5'd0) begin
        rd_i.rs1_data <= '0;
      end else begin
        rd_i.rs1_data <= regs[rd_i.rs1_addr];
      end
      if (rd_i.rs2_addr == 5'd0) begin
        rd_i.rs2_data <= '0;
      end else begin
        rd_i.rs2_data <= regs[rd_i.rs2_addr];
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
  parameter logic [rv_dec_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  wire logic                        clk,
  input  wire logic                        rst_n_i,
  input  wire logic                        jump_i,
  input  wire logic [rv_dec_pkg::XLEN-1:0] pc_jump_i,
  input  wire logic                        fetch_valid_i,
  output logic                             fetch_ready_o,
  input  wire rv_dec_pkg::instr_u          fetch_instr_i,
  input  wire rv_dec_pkg::id_ex_t          ctrl_i,
  rf_read_if.stage                         rf_o,
  output rv_dec_pkg::id_ex_t               id_ex_o,
  output logic                             id_valid_o,
  input  wire logic                        id_ready_i
);

  logic                        valid_q;
  logic                        valid_d;
  rv_dec_pkg::id_ex_t          ctrl_q;
  rv_dec_pkg::id_ex_t          ctrl_d;
  logic                        first_seen_q;
  logic                        first_seen_d;
  logic                        wfi_stop_q;
  logic                        wfi_stop_d;
  logic                        accept;
  logic [rv_dec_pkg::XLEN-1:0] pc_next;

  assign fetch_ready_o = id_ready_i && !wfi_stop_q;
  assign accept        = fetch_valid_i && fetch_ready_o;
  assign id_valid_o    = valid_q;

  // Register file is read at the acceptance edge
  assign rf_o.rs1_addr = fetch_instr_i.r_fmt.rs1;
  assign rf_o.rs2_addr = fetch_instr_i.r_fmt.rs2;
  assign rf_o.re       = id_ready_i;

  // First instruction after reset or a jump takes the loaded PC as is
  assign pc_next = first_seen_q ? (ctrl_q.pc_dec + 32'd4) : ctrl_q.pc_dec;

  always_comb begin
    valid_d      = valid_q;
    ctrl_d       = ctrl_q;
    first_seen_d = first_seen_q;
    wfi_stop_d   = wfi_stop_q;

    if (id_ready_i) begin
      if (jump_i) begin
        valid_d       = 1'b0;
        ctrl_d        = '0;
        ctrl_d.pc_dec = pc_jump_i;
        first_seen_d  = 1'b0;
        wfi_stop_d    = 1'b0;
      end else if (accept) begin
        valid_d             = 1'b1;
        ctrl_d              = ctrl_i;
        ctrl_d.pc_dec       = pc_next;
        ctrl_d.trap.pc_addr = pc_next;
        first_seen_d        = 1'b1;
        wfi_stop_d          = ctrl_i.wfi;
      end else begin
        // Bubble, PC of the last instruction kept
        valid_d       = 1'b0;
        ctrl_d        = '0;
        ctrl_d.pc_dec = ctrl_q.pc_dec;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q       <= 1'b0;
      ctrl_q        <= '0;
      ctrl_q.pc_dec <= RESET_PC;
      first_seen_q  <= 1'b0;
      wfi_stop_q    <= 1'b0;
    end else begin
      valid_q      <= valid_d;
      ctrl_q       <= ctrl_d;
      first_seen_q <= first_seen_d;
      wfi_stop_q   <= wfi_stop_d;
    end
  end

  always_comb begin
    if (jump_i) begin
      id_ex_o        = '0;
      id_ex_o.pc_dec = ctrl_q.pc_dec;
    end else if (wfi_stop_q) begin
      id_ex_o        = '0;
      id_ex_o.pc_dec = ctrl_q.pc_dec;
      id_ex_o.wfi    = 1'b1;
    end else begin
      id_ex_o = ctrl_q;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rv_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_top #(
  parameter logic [rv_dec_pkg::XLEN-1:0] RESET_PC = 32'h0000_0000
) (
  input  wire logic                        clk,
  input  wire logic                        rst_n_i,
  input  wire logic                        jump_i,
  input  wire logic [rv_dec_pkg::XLEN-1:0] pc_jump_i,
  input  wire logic                        fetch_valid_i,
  output logic                             fetch_ready_o,
  input  wire logic [rv_dec_pkg::XLEN-1:0] fetch_instr_i,
  input  wire logic                        wb_we_i,
  input  wire logic [4:0]                  wb_rd_addr_i,
  input  wire logic [rv_dec_pkg::XLEN-1:0] wb_rd_data_i,
  output rv_dec_pkg::id_ex_t               id_ex_o,
  output logic [rv_dec_pkg::XLEN-1:0]      rs1_data_o,
  output logic [rv_dec_pkg::XLEN-1:0]      rs2_data_o,
  output logic                             id_valid_o,
  input  wire logic                        id_ready_i
);

  rv_dec_pkg::id_ex_t dec_ctrl;

  rf_read_if u_rf_if ();

  instr_decoder u_decoder (
    .instr_i (fetch_instr_i),
    .ctrl_o  (dec_ctrl)
  );

  decode_stage #(
    .RESET_PC (RESET_PC)
  ) u_stage (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .jump_i        (jump_i),
    .pc_jump_i     (pc_jump_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_instr_i (fetch_instr_i),
    .ctrl_i        (dec_ctrl),
    .rf_o          (u_rf_if.stage),
    .id_ex_o       (id_ex_o),
    .id_valid_o    (id_valid_o),
    .id_ready_i    (id_ready_i)
  );

  register_file u_rf (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .rd_i      (u_rf_if.rf),
    .we_i      (wb_we_i),
    .rd_addr_i (wb_rd_addr_i),
    .rd_data_i (wb_rd_data_i)
  );

  assign rs1_data_o = u_rf_if.rs1_data;
  assign rs2_data_o = u_rf_if.rs2_data;

endmodule

`default_nettype wire

//--- dv/rv_decode_props.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_props (
  input wire logic               clk,
  input wire logic               rst_n_i,
  input wire logic               jump_i,
  input wire logic               fetch_valid_i,
  input wire logic [31:0]        fetch_instr_i,
  input wire logic               fetch_ready_o,
  input wire logic               id_valid_o,
  input wire logic               id_ready_i,
  input wire rv_dec_pkg::id_ex_t id_ex_o
);

  // WFI with rd, rs1 and funct3 all zero
  localparam logic [31:0] WFI_WORD = 32'h1050_0073;

  valid_held: assert property (@(posedge clk) disable iff (!rst_n_i)
    (id_valid_o && !id_ready_i && !jump_i) |=> id_valid_o)
    else $error("id_valid_o fell under back-pressure");

  // A jump overrides the output mux, so it is left out here
  word_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (id_valid_o && !id_ready_i && !jump_i) ##1 !jump_i |-> $stable(id_ex_o))
    else $error("id_ex_o changed under back-pressure");

  wfi_blocks_fetch: assert property (@(posedge clk) disable iff (!rst_n_i)
    (fetch_valid_i && fetch_ready_o && !jump_i && (fetch_instr_i == WFI_WORD))
    |=> !fetch_ready_o)
    else $error("fetch_ready_o high after an accepted WFI");

  // Only a jump releases the stop
  wfi_stop_held: assert property (@(posedge clk) disable iff (!rst_n_i)
    (!fetch_ready_o && id_ready_i && !jump_i) |=> !fetch_ready_o)
    else $error("WFI stop released without a jump");

  trap_needs_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
    id_ex_o.trap.active |-> id_valid_o)
    else $error("trap flag without id_valid_o");

endmodule

bind decode_stage rv_decode_props u_props (
  .clk           (clk),
  .rst_n_i       (rst_n_i),
  .jump_i        (jump_i),
  .fetch_valid_i (fetch_valid_i),
  .fetch_instr_i (fetch_instr_i),
  .fetch_ready_o (fetch_ready_o),
  .id_valid_o    (id_valid_o),
  .id_ready_i    (id_ready_i),
  .id_ex_o       (id_ex_o)
);

`default_nettype wire

//--- dv/rv_decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_tb;

  localparam logic [31:0] RESET_PC  = 32'h8000_0000;
  localparam int          MAX_CYCLE = 2000;

  logic               clk;
  logic               rst_n_i;
  logic               jump_i;
  logic [31:0]        pc_jump_i;
  logic               fetch_valid_i;
  logic               fetch_ready_o;
  logic [31:0]        fetch_instr_i;
  logic               wb_we_i;
  logic [4:0]         wb_rd_addr_i;
  logic [31:0]        wb_rd_data_i;
  rv_dec_pkg::id_ex_t id_ex;
  logic [31:0]        rs1_data_o;
  logic [31:0]        rs2_data_o;
  logic               id_valid_o;
  logic               id_ready_i;

  int          errors;
  int          checks;
  int          cycles;
  integer      seed;
  logic [31:0] rf_model [0:31];

  rv_decode_top #(
    .RESET_PC (RESET_PC)
  ) u_dut (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .jump_i        (jump_i),
    .pc_jump_i     (pc_jump_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_instr_i (fetch_instr_i),
    .wb_we_i       (wb_we_i),
    .wb_rd_addr_i  (wb_rd_addr_i),
    .wb_rd_data_i  (wb_rd_data_i),
    .id_ex_o       (id_ex),
    .rs1_data_o    (rs1_data_o),
    .rs2_data_o    (rs2_data_o),
    .id_valid_o    (id_valid_o),
    .id_ready_i    (id_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLE) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLE);
      $display(">>> FAIL");
      $finish;
    end
  end

  // Encoders following the RV32I format layouts
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
  endfunction

  task automatic compare_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic expect_ops(input rv_dec_pkg::operand_src_t s1,
                            input rv_dec_pkg::operand_src_t s2,
                            input logic [31:0] imm, input logic [2:0] f3, input logic we);
    compare_val("id_valid_o", 32'(id_valid_o), 32'd1);
    compare_val("id_ex_o.rs1_op", 32'(id_ex.rs1_op), 32'(s1));
    compare_val("id_ex_o.rs2_op", 32'(id_ex.rs2_op), 32'(s2));
    compare_val("id_ex_o.imm", id_ex.imm, imm);
    compare_val("id_ex_o.f3", 32'(id_ex.f3), 32'(f3));
    compare_val("id_ex_o.we_rd", 32'(id_ex.we_rd), 32'(we));
  endtask

  // Offer one word, wait for acceptance, sample after the output edge
  task automatic send(input logic [31:0] instr);
    @(posedge clk);
    fetch_valid_i <= 1'b1;
    fetch_instr_i <= instr;
    @(negedge clk);
    while (!fetch_ready_o) @(negedge clk);
    @(posedge clk);
    fetch_valid_i <= 1'b0;
    @(negedge clk);
  endtask

  task automatic do_jump(input logic [31:0] target, input logic [31:0] old_pc);
    @(posedge clk);
    jump_i    <= 1'b1;
    pc_jump_i <= target;
    @(negedge clk);
    compare_val("id_ex_o.pc_dec", id_ex.pc_dec, old_pc);
    compare_val("id_ex_o.we_rd", 32'(id_ex.we_rd), 32'd0);
    compare_val("id_ex_o.wfi", 32'(id_ex.wfi), 32'd0);
    compare_val("id_ex_o.imm", id_ex.imm, 32'd0);
    @(posedge clk);
    jump_i <= 1'b0;
  endtask

  task automatic pc_and_jump_test();
    logic [31:0] addi;
    addi = i_type(12'd1, 5'd1, 3'd0, 5'd1, 7'h13);
    for (int i = 0; i < 3; i++) begin
      send(addi);
      compare_val("id_ex_o.pc_dec", id_ex.pc_dec, RESET_PC + 32'(4 * i));
    end
    @(posedge clk);
    jump_i    <= 1'b1;
    pc_jump_i <= 32'h8000_1000;
    @(negedge clk);
    compare_val("id_ex_o.pc_dec", id_ex.pc_dec, RESET_PC + 32'd8);
    compare_val("id_ex_o.we_rd", 32'(id_ex.we_rd), 32'd0);
    compare_val("id_ex_o.imm", id_ex.imm, 32'd0);
    @(posedge clk);
    jump_i <= 1'b0;
    send(addi);
    compare_val("id_ex_o.pc_dec", id_ex.pc_dec, 32'h8000_1000);
    send(addi);
    compare_val("id_ex_o.pc_dec", id_ex.pc_dec, 32'h8000_1004);
  endtask

  task automatic decode_fields_test();
    send(i_type(12'hFFB, 5'd1, 3'd0, 5'd3, 7'h13));
    expect_ops(rv_dec_pkg::REG_RF, rv_dec_pkg::IMM, 32'hFFFF_FFFB, 3'd0, 1'b1);
    send(i_type(12'h407, 5'd2, 3'd5, 5'd4, 7'h13));
    expect_ops(rv_dec_pkg::REG_RF, rv_dec_pkg::IMM, 32'h0000_0407, 3'd5, 1'b1);
    compare_val("id_ex_o.rshift_arith", 32'(id_ex.rshift_arith), 32'd1);
    send({20'hABCDE, 5'd5, 7'h37});
    expect_ops(rv_dec_pkg::ZERO, rv_dec_pkg::IMM, 32'hABCD_E000, 3'd0, 1'b1);
    send({20'h12345, 5'd6, 7'h17});
    expect_ops(rv_dec_pkg::PC, rv_dec_pkg::IMM, 32'h1234_5000, 3'd0, 1'b1);
    send(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd7, 7'h33));
    expect_ops(rv_dec_pkg::REG_RF, rv_dec_pkg::REG_RF, 32'd0, 3'd0, 1'b1);
    compare_val("id_ex_o.f7_alt", 32'(id_ex.f7_alt), 32'd1);
    compare_val("id_ex_o.rd_addr", 32'(id_ex.rd_addr), 32'd7);
    compare_val("id_ex_o.rs1_addr", 32'(id_ex.rs1_addr), 32'd1);
    compare_val("id_ex_o.rs2_addr", 32'(id_ex.rs2_addr), 32'd2);
    send(j_type(21'h1F_FFF8, 5'd1));
    expect_ops(rv_dec_pkg::PC, rv_dec_pkg::IMM, 32'hFFFF_FFF8, 3'd0, 1'b1);
    compare_val("id_ex_o.jump", 32'(id_ex.jump), 32'd1);
    send(i_type(12'd16, 5'd5, 3'd0, 5'd1, 7'h67));
    expect_ops(rv_dec_pkg::REG_RF, rv_dec_pkg::IMM, 32'h0000_0010, 3'd0, 1'b1);
    compare_val("id_ex_o.jump", 32'(id_ex.jump), 32'd1);
    send(b_type(13'd12, 5'd2, 5'd1, 3'd0));
    expect_ops(rv_dec_pkg::REG_RF, rv_dec_pkg::REG_RF, 32'h0000_000C, 3'd0, 1'b0);
    compare_val("id_ex_o.branch", 32'(id_ex.branch), 32'd1);
    send(i_type(12'hFFC, 5'd1, 3'd2, 5'd8, 7'h03));
    expect_ops(rv_dec_pkg::REG_RF, rv_dec_pkg::IMM, 32'hFFFF_FFFC, 3'd0, 1'b1);
    compare_val("id_ex_o.lsu", 32'(id_ex.lsu), 32'(rv_dec_pkg::LSU_LOAD));
    compare_val("id_ex_o.lsu_w", 32'(id_ex.lsu_w), 32'(rv_dec_pkg::LSU_W));
    send(s_type(12'd20, 5'd2, 5'd1, 3'd0));
    expect_ops(rv_dec_pkg::REG_RF, rv_dec_pkg::IMM, 32'h0000_0014, 3'd0, 1'b0);
    compare_val("id_ex_o.lsu", 32'(id_ex.lsu), 32'(rv_dec_pkg::LSU_STORE));
    compare_val("id_ex_o.lsu_w", 32'(id_ex.lsu_w), 32'(rv_dec_pkg::LSU_B));
  endtask

  task automatic register_file_test();
    logic [31:0] value;
    for (int i = 0; i < 8; i++) begin
      value = $random(seed);
      // x0 drops the write
      rf_model[i] = (i == 0) ? 32'd0 : value;
      @(posedge clk);
      wb_we_i      <= 1'b1;
      wb_rd_addr_i <= 5'(i);
      wb_rd_data_i <= value;
    end
    @(posedge clk);
    wb_we_i <= 1'b0;
    send(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd10, 7'h33));
    compare_val("rs1_data_o", rs1_data_o, rf_model[1]);
    compare_val("rs2_data_o", rs2_data_o, rf_model[2]);
    send(r_type(7'h00, 5'd7, 5'd0, 3'd0, 5'd10, 7'h33));
    compare_val("rs1_data_o", rs1_data_o, 32'd0);
    compare_val("rs2_data_o", rs2_data_o, rf_model[7]);
  endtask

  task automatic back_pressure_test();
    @(posedge clk);
    fetch_valid_i <= 1'b1;
    fetch_instr_i <= r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd11, 7'h33);
    @(negedge clk);
    while (!fetch_ready_o) @(negedge clk);
    // Ready drops on the acceptance edge with the next word waiting
    @(posedge clk);
    id_ready_i    <= 1'b0;
    fetch_instr_i <= r_type(7'h00, 5'd4, 5'd3, 3'd0, 5'd12, 7'h33);
    repeat (5) begin
      @(negedge clk);
      compare_val("fetch_ready_o", 32'(fetch_ready_o), 32'd0);
      compare_val("id_valid_o", 32'(id_valid_o), 32'd1);
      compare_val("rs1_data_o", rs1_data_o, rf_model[1]);
      compare_val("rs2_data_o", rs2_data_o, rf_model[2]);
      compare_val("id_ex_o.rd_addr", 32'(id_ex.rd_addr), 32'd11);
      compare_val("id_ex_o.pc_dec", id_ex.pc_dec, 32'h8000_1038);
      compare_val("id_ex_o.rs2_op", 32'(id_ex.rs2_op), 32'(rv_dec_pkg::REG_RF));
      compare_val("id_ex_o.we_rd", 32'(id_ex.we_rd), 32'd1);
    end
    @(posedge clk);
    id_ready_i <= 1'b1;
    @(posedge clk);
    fetch_valid_i <= 1'b0;
    @(negedge clk);
    compare_val("id_ex_o.rd_addr", 32'(id_ex.rd_addr), 32'd12);
    compare_val("id_ex_o.pc_dec", id_ex.pc_dec, 32'h8000_103C);
    compare_val("rs1_data_o", rs1_data_o, rf_model[3]);
    compare_val("rs2_data_o", rs2_data_o, rf_model[4]);
  endtask

  task automatic system_trap_test();
    send(i_type(12'h305, 5'd1, 3'd1, 5'd9, 7'h73));
    compare_val("id_ex_o.csr.op", 32'(id_ex.csr.op), 32'(rv_dec_pkg::RW));
    compare_val("id_ex_o.csr.addr", 32'(id_ex.csr.addr), 32'h305);
    compare_val("id_ex_o.csr.rs1_is_x0", 32'(id_ex.csr.rs1_is_x0), 32'd0);
    compare_val("id_ex_o.we_rd", 32'(id_ex.we_rd), 32'd1);
    send(32'h0000_0073);
    compare_val("id_ex_o.ecall", 32'(id_ex.ecall), 32'd1);
    send(32'h0010_0073);
    compare_val("id_ex_o.ebreak", 32'(id_ex.ebreak), 32'd1);
    send(32'h3020_0073);
    compare_val("id_ex_o.mret", 32'(id_ex.mret), 32'd1);
    do_jump(32'h8000_0200, 32'h8000_104C);
    send(32'h1234_567F);
    compare_val("id_ex_o.trap.active", 32'(id_ex.trap.active), 32'd1);
    compare_val("id_ex_o.trap.mtval", id_ex.trap.mtval, 32'h1234_567F);
    compare_val("id_ex_o.trap.pc_addr", id_ex.trap.pc_addr, 32'h8000_0200);
    compare_val("id_ex_o.pc_dec", id_ex.pc_dec, 32'h8000_0200);
  endtask

  task automatic wfi_test();
    send(32'h1050_0073);
    compare_val("fetch_ready_o", 32'(fetch_ready_o), 32'd0);
    compare_val("id_ex_o.wfi", 32'(id_ex.wfi), 32'd1);
    @(posedge clk);
    fetch_valid_i <= 1'b1;
    fetch_instr_i <= i_type(12'd3, 5'd0, 3'd0, 5'd2, 7'h13);
    repeat (4) begin
      @(negedge clk);
      compare_val("fetch_ready_o", 32'(fetch_ready_o), 32'd0);
      compare_val("id_ex_o.wfi", 32'(id_ex.wfi), 32'd1);
    end
    do_jump(32'h8000_0300, 32'h8000_0204);
    @(negedge clk);
    compare_val("fetch_ready_o", 32'(fetch_ready_o), 32'd1);
    @(posedge clk);
    fetch_valid_i <= 1'b0;
    @(negedge clk);
    compare_val("id_ex_o.wfi", 32'(id_ex.wfi), 32'd0);
    compare_val("id_ex_o.pc_dec", id_ex.pc_dec, 32'h8000_0300);
    compare_val("id_ex_o.imm", id_ex.imm, 32'd3);
  endtask

  initial begin
    errors        = 0;
    checks        = 0;
    cycles        = 0;
    seed          = 32'h491a_fd67;
    rst_n_i       = 1'b0;
    jump_i        = 1'b0;
    pc_jump_i     = '0;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    wb_we_i       = 1'b0;
    wb_rd_addr_i  = '0;
    wb_rd_data_i  = '0;
    id_ready_i    = 1'b1;
    repeat (4) @(posedge clk);
    rst_n_i <= 1'b1;

    pc_and_jump_test();
    decode_fields_test();
    register_file_test();
    back_pressure_test();
    system_trap_test();
    wfi_test();

    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_decode.f
verilog/rv_dec_pkg.sv
verilog/rf_read_if.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/rv_decode_top.sv
dv/rv_decode_props.sv
dv/rv_decode_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f rv_decode.f --top-module rv_decode_tb \
  --Mdir obj_dir -o vsim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ] || ! grep -q ">>> PASS" "$LOG"; then
  echo "simulation did not complete"
  exit 1
fi
exit 0
